//--- sim.f
rtl/qcom_pkg.sv
rtl/sync_n.sv
rtl/cmd_credit_fifo.sv
rtl/req_ack_cmd.sv
rtl/qcom_cfg.sv
rtl/net_link.sv
rtl/qcom_top.sv
verif/qcom_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module qcom_tb -f sim.f

out=$(./obj_dir/Vqcom_tb 2>&1) || true
echo "$out"

if grep -q "Simulation finished: PASS" <<< "$out"; then
    exit 0
else
    exit 1
fi

//--- verif/qcom_tb.sv
// Self-checking testbench; expected events come from a register model built with the table.
// Assumes one command in flight at a time, so read and packet events arrive in row order.
`timescale 1ns/10ps

module qcom_tb;

    localparam int FIFO_DEPTH  = 4;
    localparam int SYNC_STAGES = 2;
    localparam int N_ROWS      = 15;
    localparam int CREDIT_WAIT = 500;
    localparam int EVENT_WAIT  = 1000;

    // Expected event per row
    localparam logic [1:0] K_NONE = 2'd0;
    localparam logic [1:0] K_READ = 2'd1;
    localparam logic [1:0] K_PKT  = 2'd2;

    // One stimulus row with its expected response
    typedef struct packed {
        logic [4:0]  op;
        logic [3:0]  addr;
        logic [31:0] data;
        logic [1:0]  kind;
        logic [43:0] exp;
        logic [7:0]  dly;
    } row_t;

    logic                        i_clk;
    logic                        i_rstn;
    logic                        i_cmd_valid;
    qcom_pkg::cmd_t              i_cmd;
    logic                        o_credit;
    logic                        o_rd_valid;
    logic [qcom_pkg::DATA_W-1:0] o_rd_data;
    logic                        o_pkt_valid;
    qcom_pkg::net_pkt_t          o_pkt;
    logic [3:0]                  o_cmd_cnt;

    row_t        rows [N_ROWS];
    // Reference copy of the register file
    logic [31:0] shadow [16];
    int          n_built;
    int          seed;
    int          err_cnt;
    int          sent;
    int          returned;
    bit          mon_done;

    qcom_top #(
        .FIFO_DEPTH  (FIFO_DEPTH),
        .SYNC_STAGES (SYNC_STAGES)
    ) u_qcom_top (
        .i_clk       (i_clk),
        .i_rstn      (i_rstn),
        .i_cmd_valid (i_cmd_valid),
        .i_cmd       (i_cmd),
        .o_credit    (o_credit),
        .o_rd_valid  (o_rd_valid),
        .o_rd_data   (o_rd_data),
        .o_pkt_valid (o_pkt_valid),
        .o_pkt       (o_pkt),
        .o_cmd_cnt   (o_cmd_cnt)
    );

    // 20 ns clock
    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reporting
    ////////////////////////////////////////////////////////////////////////////
    task automatic stop_with_failure();
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            err_cnt++;
            $display("FAILED at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic report_timeout(input string what);
        $display("ERROR at %0t ns: timed out %s", $time, what);
        stop_with_failure();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Table and reference model
    ////////////////////////////////////////////////////////////////////////////
    // Expected value follows the register model at the point the row runs
    task automatic add_row(input logic [4:0] op, input logic [3:0] addr, input logic [31:0] data);
        row_t r;
        r.op   = op;
        r.addr = addr;
        r.data = data;
        r.kind = K_NONE;
        r.exp  = '0;
        r.dly  = shadow[1][7:0];
        if (op[4]) begin
            if (op[3:0] == qcom_pkg::LOP_WR) begin
                shadow[addr] = data;
            end else if (op[3:0] == qcom_pkg::LOP_RD) begin
                r.kind = K_READ;
                r.exp  = {12'h000, shadow[addr]};
            end
        end else begin
            // src, dest, code, tag, payload
            r.kind = K_PKT;
            r.exp  = {shadow[0][3:0], data[31:28], op[3:0], addr, data[27:24], data[23:0]};
        end
        rows[n_built] = r;
        n_built++;
    endtask

    task automatic build_table();
        logic [4:0] wr_op;
        logic [4:0] rd_op;
        wr_op = {1'b1, qcom_pkg::LOP_WR};
        rd_op = {1'b1, qcom_pkg::LOP_RD};
        for (int i = 0; i < 16; i++) begin
            shadow[i] = '0;
        end
        // Reset value, board id, short delay
        add_row(rd_op, 4'd0, 32'h0);
        add_row(wr_op, 4'd0, 32'd5);
        add_row(wr_op, 4'd1, 32'd3);
        // Scratch round trip
        add_row(wr_op, 4'd2, $random(seed));
        add_row(rd_op, 4'd2, 32'h0);
        add_row(5'h03, 4'd6, $random(seed));
        // Slow link from here on
        add_row(wr_op, 4'd1, 32'd40);
        add_row(5'h0a, 4'd9, $random(seed));
        // Burst of FIFO_DEPTH+3 behind slow packets
        add_row(wr_op, 4'd3, $random(seed));
        add_row(5'h05, 4'd2, $random(seed));
        add_row(rd_op, 4'd3, 32'h0);
        add_row(wr_op, 4'd15, $random(seed));
        add_row(5'h0c, 4'd7, $random(seed));
        add_row(rd_op, 4'd15, 32'h0);
        add_row(5'h01, 4'd4, $random(seed));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Credit-tracking driver
    ////////////////////////////////////////////////////////////////////////////
    function automatic int host_credits();
        return FIFO_DEPTH - sent + returned;
    endfunction

    // Every driver cycle passes here once, so no credit pulse is missed
    task automatic step_negedge();
        @(negedge i_clk);
        if (o_credit === 1'b1) begin
            returned++;
        end
        check("credits within depth", 64'(host_credits() <= FIFO_DEPTH), 64'd1);
    endtask

    task automatic send_rows();
        int wait_cnt;
        for (int r = 0; r < N_ROWS; r++) begin
            wait_cnt = 0;
            step_negedge();
            // Stall with valid low until a credit comes back
            while (host_credits() == 0) begin
                @(posedge i_clk);
                i_cmd_valid <= 1'b0;
                step_negedge();
                wait_cnt++;
                if (wait_cnt > CREDIT_WAIT) begin
                    report_timeout("waiting for a command credit");
                end
            end
            @(posedge i_clk);
            i_cmd_valid <= 1'b1;
            i_cmd       <= {rows[r].op, rows[r].addr, rows[r].data};
            sent++;
        end
        step_negedge();
        @(posedge i_clk);
        i_cmd_valid <= 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Event monitor
    ////////////////////////////////////////////////////////////////////////////
    initial begin : event_monitor
        int r;
        int gap;
        int idle;
        r        = 0;
        gap      = 0;
        idle     = 0;
        mon_done = 1'b0;
        while (!mon_done) begin
            @(negedge i_clk);
            gap++;
            idle++;
            // Rows without a response are skipped
            while (r < N_ROWS && rows[r].kind == K_NONE) begin
                r++;
            end
            if (r >= N_ROWS) begin
                mon_done = 1'b1;
            end else if (i_rstn && (o_rd_valid === 1'b1 || o_pkt_valid === 1'b1)) begin
                check("o_rd_valid with o_pkt_valid", 64'(o_rd_valid && o_pkt_valid), 64'd0);
                check("event kind", 64'(o_pkt_valid ? K_PKT : K_READ), 64'(rows[r].kind));
                if (o_rd_valid) begin
                    check("o_rd_data", 64'(o_rd_data), 64'(rows[r].exp));
                end else begin
                    check("o_pkt", 64'(o_pkt), 64'(rows[r].exp));
                    // Link delay bounds the spacing from the previous event
                    check("packet gap >= delay", 64'(gap >= int'(rows[r].dly)), 64'd1);
                end
                gap  = 0;
                idle = 0;
                r++;
            end else if (idle > EVENT_WAIT) begin
                report_timeout("waiting for a read or packet event");
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////
    initial begin : main_seq
        int wait_cnt;
        seed        = 53;
        err_cnt     = 0;
        sent        = 0;
        returned    = 0;
        n_built     = 0;
        i_rstn      = 1'b0;
        i_cmd_valid = 1'b0;
        i_cmd       = '0;
        build_table();
        repeat (8) @(posedge i_clk);
        i_rstn <= 1'b1;
        step_negedge();
        // Reset state
        check("o_credit", 64'(o_credit), 64'd0);
        check("o_rd_valid", 64'(o_rd_valid), 64'd0);
        check("o_pkt_valid", 64'(o_pkt_valid), 64'd0);
        check("o_cmd_cnt", 64'(o_cmd_cnt), 64'd0);
        send_rows();
        wait_cnt = 0;
        while (!mon_done) begin
            step_negedge();
            wait_cnt++;
            if (wait_cnt > 4 * EVENT_WAIT) begin
                report_timeout("waiting for the last expected event");
            end
        end
        repeat (2) step_negedge();
        check("o_cmd_cnt", 64'(o_cmd_cnt), 64'(N_ROWS % 16));
        check("host credits at end", 64'(host_credits()), 64'(FIFO_DEPTH));
        if (err_cnt == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            stop_with_failure();
        end
    end

endmodule

//--- rtl/qcom_top.sv
// Host starts with FIFO_DEPTH credits and sends only while it holds one.
// Link ack is crossed with SYNC_STAGES flops though both sides share i_clk.
`timescale 1ns/10ps

module qcom_top #(
    parameter int FIFO_DEPTH  = 4,
    parameter int SYNC_STAGES = 2
) (
    input  logic                        i_clk,
    input  logic                        i_rstn,
    input  logic                        i_cmd_valid,
    input  qcom_pkg::cmd_t              i_cmd,
    output logic                        o_credit,
    output logic                        o_rd_valid,
    output logic [qcom_pkg::DATA_W-1:0] o_rd_data,
    output logic                        o_pkt_valid,
    output qcom_pkg::net_pkt_t          o_pkt,
    output logic [3:0]                  o_cmd_cnt
);

    // Queue to dispatcher
    logic                       q_valid;
    qcom_pkg::cmd_t             q_cmd;
    logic                       q_pop;
    // Dispatcher to targets
    logic                       loc_req;
    logic                       net_req;
    qcom_pkg::exec_t            exec;
    logic                       cfg_ack;
    logic                       link_ack_async;
    logic                       link_ack_s;
    // Config to link
    logic [qcom_pkg::BID_W-1:0] board_id;
    logic [qcom_pkg::DLY_W-1:0] net_dly;

    cmd_credit_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .i_clk    (i_clk),
        .i_rstn   (i_rstn),
        .i_wr     (i_cmd_valid),
        .i_cmd    (i_cmd),
        .i_pop    (q_pop),
        .o_valid  (q_valid),
        .o_cmd    (q_cmd),
        .o_credit (o_credit)
    );

    req_ack_cmd u_disp (
        .i_clk         (i_clk),
        .i_rstn        (i_rstn),
        .i_valid       (q_valid),
        .i_cmd         (q_cmd),
        .o_pop         (q_pop),
        .i_sync_ack    (cfg_ack),
        .i_async_ack_s (link_ack_s),
        .o_loc_req     (loc_req),
        .o_net_req     (net_req),
        .o_exec        (exec),
        .o_cmd_cnt     (o_cmd_cnt)
    );

    sync_n #(
        .N (SYNC_STAGES)
    ) u_sync (
        .i_clk  (i_clk),
        .i_rstn (i_rstn),
        .i_d    (link_ack_async),
        .o_q    (link_ack_s)
    );

    qcom_cfg u_cfg (
        .i_clk      (i_clk),
        .i_rstn     (i_rstn),
        .i_req      (loc_req),
        .i_exec     (exec),
        .o_ack      (cfg_ack),
        .o_rd_valid (o_rd_valid),
        .o_rd_data  (o_rd_data),
        .o_board_id (board_id),
        .o_net_dly  (net_dly)
    );

    net_link u_link (
        .i_clk       (i_clk),
        .i_rstn      (i_rstn),
        .i_req       (net_req),
        .i_exec      (exec),
        .i_board_id  (board_id),
        .i_net_dly   (net_dly),
        .o_ack       (link_ack_async),
        .o_pkt_valid (o_pkt_valid),
        .o_pkt       (o_pkt)
    );

endmodule

//--- rtl/net_link.sv
// Packet goes out on a parallel port, no serial link.
// Delay and board id are sampled when the request rises and at packet build.
`timescale 1ns/10ps

module net_link (
    input  logic                       i_clk,
    input  logic                       i_rstn,
    input  logic                       i_req,
    input  qcom_pkg::exec_t            i_exec,
    input  logic [qcom_pkg::BID_W-1:0] i_board_id,
    input  logic [qcom_pkg::DLY_W-1:0] i_net_dly,
    output logic                       o_ack,
    output logic                       o_pkt_valid,
    output qcom_pkg::net_pkt_t         o_pkt
);

    logic                       req_d;
    logic                       req_rise;
    logic                       busy;
    logic                       fire;
    logic [qcom_pkg::DLY_W-1:0] dly_cnt;
    logic                       ack_r;
    logic                       pkt_valid_r;
    qcom_pkg::net_pkt_t         pkt_r;

    assign req_rise = i_req && !req_d;
    // Countdown done
    assign fire     = busy && (dly_cnt == '0);

    always_ff @(posedge i_clk) begin
        if (!i_rstn) begin
            req_d       <= 1'b0;
            busy        <= 1'b0;
            dly_cnt     <= '0;
            ack_r       <= 1'b0;
            pkt_valid_r <= 1'b0;
        end else begin
            req_d       <= i_req;
            pkt_valid_r <= fire;
            if (req_rise) begin
                busy    <= 1'b1;
                dly_cnt <= i_net_dly;
            end else if (fire) begin
                busy <= 1'b0;
            end else if (busy) begin
                dly_cnt <= dly_cnt - 1'b1;
            end
            // Ack up with the packet, down once request is gone
            if (!i_req) begin
                ack_r <= 1'b0;
            end else if (fire) begin
                ack_r <= 1'b1;
            end
        end
    end

    // Packet fields from the network view of the data word
    always_ff @(posedge i_clk) begin
        if (fire) begin
            pkt_r.src     <= i_board_id;
            pkt_r.dest    <= i_exec.data.net.dest;
            pkt_r.code    <= i_exec.op8;
            pkt_r.tag     <= i_exec.data.net.tag;
            pkt_r.payload <= i_exec.data.net.payload;
        end
    end

    assign o_ack       = ack_r;
    assign o_pkt_valid = pkt_valid_r;
    assign o_pkt       = pkt_r;

endmodule

//--- rtl/qcom_cfg.sv
// Opcodes other than write and read are acknowledged and ignored.
// Read data is valid only in the o_rd_valid cycle.
`timescale 1ns/10ps

module qcom_cfg (
    input  logic                        i_clk,
    input  logic                        i_rstn,
    input  logic                        i_req,
    input  qcom_pkg::exec_t             i_exec,
    output logic                        o_ack,
    output logic                        o_rd_valid,
    output logic [qcom_pkg::DATA_W-1:0] o_rd_data,
    output logic [qcom_pkg::BID_W-1:0]  o_board_id,
    output logic [qcom_pkg::DLY_W-1:0]  o_net_dly
);

    localparam int NREGS = 2 ** qcom_pkg::ADDR_W;

    logic [qcom_pkg::DATA_W-1:0] regs [NREGS];

    logic                        ack_r;
    logic                        start;
    logic [3:0]                  lop;
    logic [qcom_pkg::ADDR_W-1:0] addr;
    logic                        do_wr;
    logic                        do_rd;
    logic                        rd_valid_r;
    logic [qcom_pkg::DATA_W-1:0] rd_data_r;

    // Split op8 back into opcode and address
    assign lop  = i_exec.op8[7:4];
    assign addr = i_exec.op8[3:0];

    // First request cycle, before ack goes up
    assign start = i_req && !ack_r;
    assign do_wr = start && (lop == qcom_pkg::LOP_WR);
    assign do_rd = start && (lop == qcom_pkg::LOP_RD);

    ////////////////////////////////////////////////////////////////////////////
    // Handshake
    ////////////////////////////////////////////////////////////////////////////
    // Ack follows request one cycle late, both edges
    always_ff @(posedge i_clk) begin
        if (!i_rstn) begin
            ack_r <= 1'b0;
        end else begin
            ack_r <= i_req;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Register file
    ////////////////////////////////////////////////////////////////////////////
    // Write lands on the same edge that raises ack
    always_ff @(posedge i_clk) begin
        if (!i_rstn) begin
            regs <= '{default: '0};
        end else if (do_wr) begin
            regs[addr] <= i_exec.data.raw;
        end
    end

    // Read strobe
    always_ff @(posedge i_clk) begin
        if (!i_rstn) begin
            rd_valid_r <= 1'b0;
        end else begin
            rd_valid_r <= do_rd;
        end
    end

    always_ff @(posedge i_clk) begin
        if (do_rd) begin
            rd_data_r <= regs[addr];
        end
    end

    assign o_ack      = ack_r;
    assign o_rd_valid = rd_valid_r;
    assign o_rd_data  = rd_data_r;

    // Live settings for the link engine
    assign o_board_id = regs[qcom_pkg::REG_BOARD_ID][qcom_pkg::BID_W-1:0];
    assign o_net_dly  = regs[qcom_pkg::REG_NET_DLY][qcom_pkg::DLY_W-1:0];

endmodule

//--- rtl/req_ack_cmd.sv
// One command in flight at a time; op[4] picks local (1) or network (0) target.
// Acknowledges must already be in this clock domain.
`timescale 1ns/10ps

module req_ack_cmd (
    input  logic            i_clk,
    input  logic            i_rstn,
    // Queue side
    input  logic            i_valid,
    input  qcom_pkg::cmd_t  i_cmd,
    output logic            o_pop,
    // Target side
    input  logic            i_sync_ack,
    input  logic            i_async_ack_s,
    output logic            o_loc_req,
    output logic            o_net_req,
    output qcom_pkg::exec_t o_exec,
    // Accepted-command count, wraps
    output logic [3:0]      o_cmd_cnt
);

    typedef enum logic [1:0] {
        IDLE    = 2'b00,
        LOC_REQ = 2'b01,
        NET_REQ = 2'b10,
        ACK     = 2'b11
    } state_t;

    state_t          state_r;
    state_t          state_n;
    logic            ack;
    qcom_pkg::exec_t exec_r;
    logic [3:0]      cnt_r;

    // Either target may answer; only one request is ever open
    assign ack = i_sync_ack | i_async_ack_s;

    // Take a command whenever idle and the queue has one
    assign o_pop = (state_r == IDLE) && i_valid;

    ////////////////////////////////////////////////////////////////////////////
    // Four-phase FSM
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        state_n = state_r;
        case (state_r)
            IDLE: begin
                if (i_valid) begin
                    state_n = i_cmd.op[4] ? LOC_REQ : NET_REQ;
                end
            end
            LOC_REQ, NET_REQ: begin
                // Drop request as soon as ack is seen
                if (ack) begin
                    state_n = ACK;
                end
            end
            ACK: begin
                // Wait for target to release ack
                if (!ack) begin
                    state_n = IDLE;
                end
            end
            default: begin
                state_n = IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_rstn) begin
            state_r <= IDLE;
            cnt_r   <= '0;
        end else begin
            state_r <= state_n;
            if (o_pop) begin
                cnt_r <= cnt_r + 1'b1;
            end
        end
    end

    // Latched command, stable until next pop
    always_ff @(posedge i_clk) begin
        if (o_pop) begin
            exec_r.op8      <= {i_cmd.op[3:0], i_cmd.addr};
            exec_r.data.raw <= i_cmd.data;
        end
    end

    // Requests are decoded straight from state, so no glitches
    assign o_loc_req = (state_r == LOC_REQ);
    assign o_net_req = (state_r == NET_REQ);
    assign o_exec    = exec_r;
    assign o_cmd_cnt = cnt_r;

    // Local and network channels never overlap, request or ack
    a_req_mutex : assert property (@(posedge i_clk) disable iff (!i_rstn)
        !((o_loc_req || i_sync_ack) && (o_net_req || i_async_ack_s)))
        else $error("local and network handshakes overlap");

endmodule

//--- rtl/cmd_credit_fifo.sv
// Sender must respect credits; a write into a full queue is dropped and flagged.
`timescale 1ns/10ps

module cmd_credit_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic            i_clk,
    input  logic            i_rstn,
    input  logic            i_wr,
    input  qcom_pkg::cmd_t  i_cmd,
    input  logic            i_pop,
    output logic            o_valid,
    output qcom_pkg::cmd_t  o_cmd,
    output logic            o_credit
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    // Storage, payload only
    qcom_pkg::cmd_t mem [FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_wr;
    logic             do_rd;
    logic             credit_r;

    // Gate with fullness and emptiness
    assign do_wr = i_wr && (count != FIFO_DEPTH[CNT_W-1:0]);
    assign do_rd = i_pop && o_valid;

    always_ff @(posedge i_clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= i_cmd;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Pointers, occupancy and credit return
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge i_clk) begin
        if (!i_rstn) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            credit_r <= 1'b0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves count unchanged
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
            // One credit back per command handed on
            credit_r <= do_rd;
        end
    end

    assign o_valid  = (count != '0);
    assign o_cmd    = mem[rd_ptr];
    assign o_credit = credit_r;

    // Host credit counter should make this impossible
    a_no_overflow : assert property (@(posedge i_clk) disable iff (!i_rstn)
        i_wr |-> (count != FIFO_DEPTH[CNT_W-1:0]))
        else $error("command written into full queue");

endmodule

//--- rtl/sync_n.sv
// Level synchronizer only; pulses shorter than one clock may be lost.
`timescale 1ns/10ps

module sync_n #(
    parameter int N = 2
) (
    input  logic i_clk,
    input  logic i_rstn,
    input  logic i_d,
    output logic o_q
);

    // chain[0] is the raw input, chain[N] the synchronized level
    logic [N:0] chain;

    assign chain[0] = i_d;

    always_ff @(posedge i_clk) begin
        if (!i_rstn) begin
            chain[N:1] <= '0;
        end else begin
            chain[N:1] <= chain[N-1:0];
        end
    end

    assign o_q = chain[N];

endmodule

//--- rtl/qcom_pkg.sv
// Shared types for the command peripheral; the command word layout is fixed at 41 bits.
// Local ops set op[4], and only the low four opcode bits travel on to the targets.
package qcom_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Field widths
    ////////////////////////////////////////////////////////////////////////////
    localparam int OP_W   = 5;
    localparam int ADDR_W = 4;
    localparam int DATA_W = 32;
    // Board id and network delay taken from config registers
    localparam int BID_W  = 4;
    localparam int DLY_W  = 8;

    // Host command as it enters the queue
    typedef struct packed {
        logic [OP_W-1:0]   op;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
    } cmd_t;

    // Network view of the data word
    typedef struct packed {
        logic [3:0]  dest;
        logic [3:0]  tag;
        logic [23:0] payload;
    } net_fields_t;

    // Raw register value or network fields, same 32 bits
    typedef union packed {
        logic [DATA_W-1:0] raw;
        net_fields_t       net;
    } cmd_data_u;

    // Latched command seen by both targets
    // op8 holds op[3:0] in the upper nibble, addr below
    typedef struct packed {
        logic [7:0] op8;
        cmd_data_u  data;
    } exec_t;

    // Outgoing board packet
    typedef struct packed {
        logic [3:0]  src;
        logic [3:0]  dest;
        logic [7:0]  code;
        logic [3:0]  tag;
        logic [23:0] payload;
    } net_pkt_t;

    ////////////////////////////////////////////////////////////////////////////
    // Local opcodes and register map
    ////////////////////////////////////////////////////////////////////////////
    localparam logic [3:0] LOP_WR = 4'd0;
    localparam logic [3:0] LOP_RD = 4'd1;

    localparam logic [ADDR_W-1:0] REG_BOARD_ID = 4'd0;
    localparam logic [ADDR_W-1:0] REG_NET_DLY  = 4'd1;
    // Addresses 2..15 are scratch

endpackage
